/* logic/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;     // Register or instruction value
  typedef logic [15:0] half_t;     // One half-word
  typedef logic [2:0]  reg_idx_t;  // Register number
  typedef logic [1:0]  half_en_t;  // Bit 0 lower half, bit 1 upper half
  typedef logic [14:0] pc_t;       // Program counter

  localparam int NUM_REGS = 8;
  localparam int HALF_W   = $bits(half_t);

  // Reset values
  localparam word_t WORD_RESET = '0;
  localparam pc_t   PC_RESET   = '0;

  // Half-word write enables
  localparam half_en_t WB_NONE = 2'b00;
  localparam half_en_t WB_LO   = 2'b01;
  localparam half_en_t WB_HI   = 2'b10;
  localparam half_en_t WB_BOTH = 2'b11;

endpackage

/* logic/isa_pkg.sv */
package isa_pkg;

  import core_pkg::*;

  typedef enum logic [1:0] {
    type_nop   = 2'b00,
    type_arith = 2'b01,
    type_mem   = 2'b10,  // Decoded as a no-op
    type_audio = 2'b11   // Decoded as a no-op
  } instr_type_e;

  typedef logic [2:0] op_t;

  localparam op_t op_add      = 3'b001;
  localparam op_t op_inc      = 3'b011;
  localparam op_t op_mov_lo   = 3'b101;
  localparam op_t op_mov_hi   = 3'b110;
  localparam op_t op_mov_full = 3'b111;

  // Bit positions in the instruction word
  localparam int IMM_FLAG_BIT = 31;
  localparam int TYPE_LSB     = 29;
  localparam int OP_LSB       = 26;
  localparam int RS1_LSB      = 19;
  localparam int RS2_LSB      = 16;
  localparam int IMM_LSB      = 0;

  function automatic logic instr_imm_flag(word_t instr);
    return instr[IMM_FLAG_BIT];
  endfunction

  function automatic instr_type_e instr_type(word_t instr);
    return instr_type_e'(instr[TYPE_LSB +: $bits(instr_type_e)]);
  endfunction

  function automatic op_t instr_op(word_t instr);
    return instr[OP_LSB +: $bits(op_t)];
  endfunction

  function automatic reg_idx_t instr_rs1(word_t instr);
    return instr[RS1_LSB +: $bits(reg_idx_t)];
  endfunction

  function automatic reg_idx_t instr_rs2(word_t instr);
    return instr[RS2_LSB +: $bits(reg_idx_t)];
  endfunction

  function automatic half_t instr_imm(word_t instr);
    return instr[IMM_LSB +: $bits(half_t)];
  endfunction

endpackage

/* logic/pipe_ifs.sv */
`timescale 1ns/100ps

// Decode/execute pipeline register
interface dec_ex_if;
  import core_pkg::*;
  import isa_pkg::*;

  op_t      alu_op;
  logic     mov;        // Result is operand_b
  word_t    operand_a;
  word_t    operand_b;
  half_en_t wb_en;      // Non-zero for a live instruction
  reg_idx_t wb_reg;

  modport producer (output alu_op, mov, operand_a, operand_b, wb_en, wb_reg);
  modport consumer (input alu_op, mov, operand_a, operand_b, wb_en, wb_reg);
  modport monitor (input wb_en, wb_reg);
endinterface

// Execute/writeback pipeline register
interface ex_wb_if;
  import core_pkg::*;

  half_en_t wb_en;
  reg_idx_t wb_reg;
  word_t    wb_data;

  modport producer (output wb_en, wb_reg, wb_data);
  modport consumer (input wb_en, wb_reg, wb_data);
  modport monitor (input wb_en, wb_reg);
endinterface

/* logic/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
  parameter int PC_WIDTH = $bits(core_pkg::pc_t)
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  stall,
  input  core_pkg::word_t       instr_data,  // Word at instr_addr, same cycle
  output logic [PC_WIDTH-1:0]   instr_addr,
  output core_pkg::word_t       fd_instr
);
  import core_pkg::*;

  logic [PC_WIDTH-1:0] pc;

  assign instr_addr = pc;

  // Stall holds both pc and the instruction register
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      pc       <= PC_WIDTH'(PC_RESET);
      fd_instr <= WORD_RESET;  // Zero word decodes as a no-op
    end else if (!stall) begin
      pc       <= pc + 1'b1;
      fd_instr <= instr_data;
    end
  end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                stall,
  input  core_pkg::word_t     fd_instr,
  output core_pkg::reg_idx_t  rs1,
  output core_pkg::reg_idx_t  rs2,
  input  core_pkg::word_t     rs1_val,
  input  core_pkg::word_t     rs2_val,
  dec_ex_if.producer          dx
);
  import core_pkg::*;
  import isa_pkg::*;

  logic        imm_flag;
  instr_type_e itype;
  op_t         op;
  half_t       imm;
  logic        is_arith;
  logic        is_move;
  word_t       operand_b_sel;
  half_en_t    wb_en_next;

  // Field split
  assign imm_flag = instr_imm_flag(fd_instr);
  assign itype    = instr_type(fd_instr);
  assign op       = instr_op(fd_instr);
  assign imm      = instr_imm(fd_instr);
  assign rs1      = instr_rs1(fd_instr);
  assign rs2      = instr_rs2(fd_instr);

  assign is_arith = (itype == type_arith);
  assign is_move  = is_arith && (op inside {op_mov_lo, op_mov_hi, op_mov_full});

  // Second operand, immediate placed in the half it targets
  always_comb begin
    operand_b_sel = rs2_val;
    if (imm_flag) begin
      if (op == op_add || op == op_mov_lo) begin
        operand_b_sel = {half_t'(0), imm};
      end else if (op == op_mov_hi) begin
        operand_b_sel = {imm, half_t'(0)};
      end
    end
  end

  always_comb begin
    case (itype)
      type_arith: begin
        case (op)
          op_mov_lo: wb_en_next = WB_LO;
          op_mov_hi: wb_en_next = WB_HI;
          default:   wb_en_next = WB_BOTH;  // Other arithmetic and move full
        endcase
      end
      default: wb_en_next = WB_NONE;  // Nop, memory and audio
    endcase
  end

  // Control half of the decode/execute register
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      dx.wb_en  <= WB_NONE;
      dx.wb_reg <= '0;
      dx.alu_op <= '0;
      dx.mov    <= 1'b0;
    end else begin
      dx.wb_en  <= stall ? WB_NONE : wb_en_next;  // Bubble on stall
      dx.wb_reg <= rs1;
      dx.alu_op <= op;
      dx.mov    <= is_move;
    end
  end

  // Operand payload
  always_ff @(posedge clk) begin
    dx.operand_a <= rs1_val;
    dx.operand_b <= operand_b_sel;
  end

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
  input  core_pkg::reg_idx_t  rs1,
  input  core_pkg::reg_idx_t  rs2,
  input  core_pkg::word_t     fd_instr,
  dec_ex_if.monitor           dx,
  ex_wb_if.monitor            xw,
  output logic                stall
);
  import core_pkg::*;
  import isa_pkg::*;

  logic dx_live;
  logic xw_live;
  logic rs1_hit;
  logic rs2_hit;
  logic reads_rs2;

  assign dx_live = (dx.wb_en != WB_NONE);
  assign xw_live = (xw.wb_en != WB_NONE);

  // Destination still in flight, not yet in the register file
  assign rs1_hit = (dx_live && dx.wb_reg == rs1) || (xw_live && xw.wb_reg == rs1);
  assign rs2_hit = (dx_live && dx.wb_reg == rs2) || (xw_live && xw.wb_reg == rs2);

  assign reads_rs2 = (instr_op(fd_instr) != op_inc);  // Increment has one source

  assign stall = (instr_type(fd_instr) == type_arith) && (rs1_hit || (reads_rs2 && rs2_hit));

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
  input  logic         clk,
  input  logic         resetn,
  dec_ex_if.consumer   dx,
  ex_wb_if.producer    xw
);
  import core_pkg::*;
  import isa_pkg::*;

  word_t alu_result;
  word_t result;

  always_comb begin
    case (dx.alu_op)
      op_add:  alu_result = dx.operand_a + dx.operand_b;
      op_inc:  alu_result = dx.operand_a + word_t'(1);
      default: alu_result = '0;  // Unlisted operations give zero
    endcase
  end

  assign result = dx.mov ? dx.operand_b : alu_result;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      xw.wb_en  <= WB_NONE;
      xw.wb_reg <= '0;
    end else begin
      xw.wb_en  <= dx.wb_en;
      xw.wb_reg <= dx.wb_reg;
    end
  end

  always_ff @(posedge clk) begin
    xw.wb_data <= result;
  end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic                clk,
  input  logic                resetn,
  input  core_pkg::reg_idx_t  rs1,
  input  core_pkg::reg_idx_t  rs2,
  output core_pkg::word_t     rs1_val,
  output core_pkg::word_t     rs2_val,
  ex_wb_if.consumer           xw
);
  import core_pkg::*;

  word_t regs [NUM_REGS];

  // Combinational read ports
  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  // Each half written only when its enable bit is set
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= WORD_RESET;
      end
    end else begin
      if (xw.wb_en[0]) begin
        regs[xw.wb_reg][HALF_W-1:0] <= xw.wb_data[HALF_W-1:0];  // Lower half
      end
      if (xw.wb_en[1]) begin
        regs[xw.wb_reg][2*HALF_W-1:HALF_W] <= xw.wb_data[2*HALF_W-1:HALF_W];  // Upper half
      end
    end
  end

endmodule

/* logic/pipeline_cpu.sv */
`timescale 1ns/100ps

module pipeline_cpu #(
  parameter int PC_WIDTH = $bits(core_pkg::pc_t)
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  core_pkg::word_t       instr_data,
  output logic [PC_WIDTH-1:0]   instr_addr,
  output logic                  stall,
  output core_pkg::half_en_t    wb_en,    // Write at the next rising edge
  output core_pkg::reg_idx_t    wb_reg,
  output core_pkg::word_t       wb_data
);
  import core_pkg::*;

  word_t    fd_instr;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_val;
  word_t    rs2_val;

  dec_ex_if dx ();
  ex_wb_if  xw ();

  fetch_stage #(
    .PC_WIDTH (PC_WIDTH)
  ) fetch_stage_i (
    .clk        (clk),
    .resetn     (resetn),
    .stall      (stall),
    .instr_data (instr_data),
    .instr_addr (instr_addr),
    .fd_instr   (fd_instr)
  );

  decode_stage decode_stage_i (
    .clk      (clk),
    .resetn   (resetn),
    .stall    (stall),
    .fd_instr (fd_instr),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .dx       (dx.producer)
  );

  hazard_unit hazard_unit_i (
    .rs1      (rs1),
    .rs2      (rs2),
    .fd_instr (fd_instr),
    .dx       (dx.monitor),
    .xw       (xw.monitor),
    .stall    (stall)
  );

  execute_stage execute_stage_i (
    .clk    (clk),
    .resetn (resetn),
    .dx     (dx.consumer),
    .xw     (xw.producer)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .resetn  (resetn),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .xw      (xw.consumer)
  );

  // Writeback slot seen from outside
  assign wb_en   = xw.wb_en;
  assign wb_reg  = xw.wb_reg;
  assign wb_data = xw.wb_data;

endmodule

/* sim/cpu_asserts.sv */
`timescale 1ns/100ps

module cpu_asserts #(
  parameter int PC_WIDTH = $bits(core_pkg::pc_t)
) (
  input logic                clk,
  input logic                resetn,
  input logic                stall,
  input logic [PC_WIDTH-1:0] instr_addr,
  input core_pkg::half_en_t  wb_en,
  input core_pkg::half_en_t  dx_wb_en   // Decode/execute register enable
);
  import core_pkg::*;

  int fail_count = 0;  // Read by the testbench

  reset_quiet: assert property (@(negedge clk) !resetn |-> wb_en == WB_NONE)
    else begin fail_count++; $error("wb_en non-zero while in reset"); end

  // Fetch holds while stalled
  stall_holds_pc: assert property (@(posedge clk) disable iff (!resetn)
    stall |=> instr_addr == $past(instr_addr))
    else begin fail_count++; $error("instr_addr moved during a stall"); end

  stall_bubble: assert property (@(posedge clk) disable iff (!resetn)
    stall |=> dx_wb_en == WB_NONE)
    else begin fail_count++; $error("live instruction entered execute during a stall"); end

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;
  import core_pkg::*;
  import isa_pkg::*;

  localparam int PC_WIDTH     = $bits(pc_t);
  localparam int MEM_DEPTH    = 512;
  localparam int RESET_CYCLES = 8;
  localparam int SEC_PLAIN    = 0;
  localparam int SEC_DISJOINT = 1;  // Must never stall
  localparam int SEC_CHAIN    = 2;  // Must stall at least once

  typedef struct packed {
    half_en_t en;
    reg_idx_t rd;
    word_t    data;
  } wr_t;

  logic                clk;
  logic                resetn;
  word_t               instr_data;
  logic [PC_WIDTH-1:0] instr_addr;
  logic                stall;
  half_en_t            wb_en;
  reg_idx_t            wb_reg;
  word_t               wb_data;

  word_t       prog_mem [MEM_DEPTH];
  int          section_of [MEM_DEPTH];
  int          prog_len = 0;
  int          cur_section = SEC_PLAIN;
  word_t       model_regs [NUM_REGS];
  wr_t         exp_q [$];
  int          exp_total;
  int          write_count = 0;
  int          chain_stalls = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state = 32'd46;

  pipeline_cpu #(
    .PC_WIDTH (PC_WIDTH)
  ) pipeline_cpu_i (
    .clk        (clk),
    .resetn     (resetn),
    .instr_data (instr_data),
    .instr_addr (instr_addr),
    .stall      (stall),
    .wb_en      (wb_en),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  bind pipeline_cpu cpu_asserts #(.PC_WIDTH(PC_WIDTH)) cpu_asserts_i (
    .clk        (clk),
    .resetn     (resetn),
    .stall      (stall),
    .instr_addr (instr_addr),
    .wb_en      (wb_en),
    .dx_wb_en   (dx.wb_en)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic word_t encode(input logic imm_f, input logic [1:0] ty, input op_t op,
                                   input reg_idx_t rd, input reg_idx_t rs, input half_t imm);
    return {imm_f, ty, op, 4'b0000, rd, rs, imm};  // Bits 25:22 unused
  endfunction

  // Expected write of one instruction against the register model
  function automatic wr_t ref_write(input word_t w);
    wr_t   r;
    word_t a;
    word_t b;
    op_t   op;
    op     = w[28:26];
    a      = model_regs[w[21:19]];
    b      = model_regs[w[18:16]];
    r.en   = WB_NONE;
    r.rd   = w[21:19];
    r.data = '0;
    if (w[31] && (op == op_add || op == op_mov_lo)) begin
      b = {16'h0000, w[15:0]};
    end else if (w[31] && op == op_mov_hi) begin
      b = {w[15:0], 16'h0000};  // Immediate lands in the upper half
    end
    if (w[30:29] == 2'b01) begin
      r.en = (op == op_mov_lo) ? WB_LO : (op == op_mov_hi) ? WB_HI : WB_BOTH;
      case (op)
        op_add:                          r.data = a + b;
        op_inc:                          r.data = a + 32'd1;
        op_mov_lo, op_mov_hi, op_mov_full: r.data = b;
        default:                         r.data = '0;
      endcase
    end
    return r;
  endfunction

  task automatic append_word(input word_t w);
    prog_mem[prog_len]   = w;
    section_of[prog_len] = cur_section;
    prog_len++;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Program memory, word for the current pc
  always @(posedge clk) begin
    #1;
    instr_data = (int'(instr_addr) < prog_len) ? prog_mem[instr_addr[8:0]] : '0;
  end

  always @(posedge clk) begin
    if (resetn) begin
      cycle_count++;
      if (cycle_count > prog_len * 4 + 50) begin
        abort_run("Timeout: the program did not drain in time");
      end
    end
  end

  always @(negedge clk) begin
    wr_t exp_wr;
    int  idx;
    if (pipeline_cpu_i.cpu_asserts_i.fail_count != 0) begin
      abort_run("An assertion on the pipeline failed");
    end else if (!resetn) begin
      check_value("wb_en", 32'(wb_en), 32'(WB_NONE));
    end else if (wb_en != WB_NONE) begin
      if (exp_q.size() == 0) begin
        abort_run("Register write seen after the model ran out of writes");
      end else begin
        exp_wr = exp_q.pop_front();
        check_value("wb_en", 32'(wb_en), 32'(exp_wr.en));
        check_value("wb_reg", 32'(wb_reg), 32'(exp_wr.rd));
        // Only the enabled halves reach the register file
        check_value("wb_data", wb_data & {{16{wb_en[1]}}, {16{wb_en[0]}}},
                    exp_wr.data & {{16{exp_wr.en[1]}}, {16{exp_wr.en[0]}}});
        write_count++;
      end
    end else if (write_count == 0) begin
      check_value("stall", 32'(stall), 32'd0);  // Quiet until the first write
    end
    if (resetn && stall) begin
      idx = int'(instr_addr) - 1;  // Word held in decode
      if (section_of[idx] == SEC_DISJOINT) begin
        abort_run("Stall raised inside the block with disjoint registers");
      end else if (section_of[idx] == SEC_CHAIN) begin
        chain_stalls++;
      end
    end
  end

  initial begin
    wr_t wr;
    resetn     = 1'b0;
    instr_data = '0;
    // Arithmetic and moves, first two words independent
    append_word(encode(1'b1, type_arith, op_mov_lo, 3'd0, 3'd4, 16'h1234));
    append_word(encode(1'b1, type_arith, op_mov_lo, 3'd1, 3'd5, 16'h0011));
    append_word(encode(1'b1, type_arith, op_mov_hi, 3'd0, 3'd0, 16'hABCD));
    append_word(encode(1'b1, type_arith, op_mov_hi, 3'd1, 3'd0, 16'h2200));
    append_word(encode(1'b0, type_arith, op_add, 3'd1, 3'd0, 16'h0000));
    append_word(encode(1'b1, type_arith, op_add, 3'd0, 3'd0, 16'h0100));
    append_word(encode(1'b0, type_arith, op_inc, 3'd5, 3'd0, 16'h0000));
    append_word(encode(1'b1, type_arith, op_mov_lo, 3'd6, 3'd0, 16'h7777));
    append_word(encode(1'b0, type_arith, 3'b010, 3'd6, 3'd1, 16'h0000));
    append_word(encode(1'b0, type_arith, op_mov_full, 3'd7, 3'd0, 16'h0000));
    append_word(encode(1'b0, type_arith, op_mov_lo, 3'd7, 3'd1, 16'h0000));
    append_word(encode(1'b0, type_arith, op_mov_hi, 3'd6, 3'd1, 16'h0000));
    append_word(encode(1'b0, type_arith, op_add, 3'd7, 3'd6, 16'h0000));  // Merged values
    append_word(encode(1'b1, type_arith, 3'b100, 3'd3, 3'd2, 16'h00FF));
    append_word(encode(1'b0, type_arith, op_mov_full, 3'd3, 3'd7, 16'h0000));
    // No-write words
    append_word('0);
    append_word(encode(1'b1, 2'b10, op_add, 3'd1, 3'd2, 16'hFFFF));
    append_word(encode(1'b0, 2'b11, op_mov_full, 3'd3, 3'd4, 16'h5A5A));
    append_word(encode(1'b0, type_nop, op_inc, 3'd2, 3'd2, 16'h0001));
    cur_section = SEC_DISJOINT;
    for (int i = 0; i < 6; i++) begin
      append_word(encode(1'b0, type_arith, op_add, 3'(i), 3'((i + 4) % 8), 16'h0000));
    end
    cur_section = SEC_CHAIN;
    append_word(encode(1'b1, type_arith, op_mov_lo, 3'd2, 3'd2, 16'h0005));
    append_word(encode(1'b0, type_arith, op_inc, 3'd2, 3'd0, 16'h0000));
    append_word(encode(1'b0, type_arith, op_inc, 3'd2, 3'd0, 16'h0000));
    append_word(encode(1'b0, type_arith, op_add, 3'd3, 3'd2, 16'h0000));
    append_word(encode(1'b1, type_arith, op_add, 3'd3, 3'd3, 16'h0010));
    cur_section = SEC_PLAIN;
    for (int i = 0; i < 200; i++) begin
      rng_state = xorshift(rng_state);
      append_word(rng_state);
    end

    // In-order model run builds the expected write queue
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < prog_len; i++) begin
      wr = ref_write(prog_mem[i]);
      if (wr.en != WB_NONE) begin
        exp_q.push_back(wr);
        if (wr.en[0]) model_regs[wr.rd][15:0] = wr.data[15:0];
        if (wr.en[1]) model_regs[wr.rd][31:16] = wr.data[31:16];
      end
    end
    exp_total = exp_q.size();

    repeat (RESET_CYCLES) @(posedge clk);
    #1 resetn = 1'b1;
    while (int'(instr_addr) < prog_len + 4) @(negedge clk);
    @(negedge clk);
    @(negedge clk);
    check_value("write_count", write_count, exp_total);
    if (chain_stalls == 0) begin
      abort_run("No stall seen during the dependent chain");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* sim.f */
logic/core_pkg.sv
logic/isa_pkg.sv
logic/pipe_ifs.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/reg_file.sv
logic/pipeline_cpu.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

/* Makefile */
SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

obj_dir/Vcpu_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f sim.f

clean:
	rm -rf obj_dir sim.log
